// ==== hw/tlb_pkg.sv ====
package tlb_pkg;

	// ==============================
	// Sizes
	// ==============================
	localparam int TLB_SETS = 32;	// Sets per way
	localparam int TLB_ASSOC = 4;	// Number of ways
	localparam int SET_BITS = 5;	// Set index width
	localparam int WAY_BITS = 2;	// Way number width used for the victim
	localparam int LOG_PAGESIZE = 12;	// 4 KB pages
	localparam int VADR_W = 32;
	localparam int PADR_W = 32;
	localparam int ASID_W = 8;
	localparam int ID_W = 4;
	// The tag is the virtual page number above the set index
	localparam int TAG_W = VADR_W - LOG_PAGESIZE - SET_BITS;
	localparam int PPN_W = PADR_W - LOG_PAGESIZE;	// Physical page number

	// ==============================
	// Entry and port structs
	// ==============================
	// One translation entry as stored in a way
	typedef struct packed {
		logic valid;	// Entry holds a translation
		logic glb;	// Global page matches any address space
		logic nru;	// Set when the entry was used recently
		logic [ASID_W-1:0] asid;
		logic [SET_BITS-1:0] vset;	// Set the virtual page selects, used by the fill
		logic [TAG_W-1:0] tag;
		logic [PPN_W-1:0] ppn;
	} tlb_entry_t;

	typedef struct packed {
		logic [ID_W-1:0] id;	// Request id echoed in the response
		logic [ASID_W-1:0] asid;
		logic [VADR_W-1:0] vadr;
	} lookup_req_t;

	// A response carries the virtual address too so a miss can be reported
	typedef struct packed {
		logic [ID_W-1:0] id;
		logic hit;
		logic [PADR_W-1:0] padr;
		logic [ASID_W-1:0] asid;
		logic [VADR_W-1:0] vadr;
	} lookup_rsp_t;

	// Write broadcast from the fill controller to all ways
	typedef struct packed {
		logic [SET_BITS-1:0] set;
		logic [TLB_ASSOC-1:0] we;	// One write enable per way
		tlb_entry_t [TLB_ASSOC-1:0] entry;	// Each way picks its own slot
	} way_wr_t;

	// Fill controller states
	typedef enum logic [2:0] {
		CLEAR,	// Wipe one set per cycle after reset
		IDLE,
		DRAIN,	// Let in-flight NRU write-backs land
		READ,
		PICK,
		WRITE,
		ACK
	} fill_state_e;

endpackage

// ==== hw/tlb_way.sv ====
`timescale 1ns/1ps

module tlb_way #(
	parameter int way_no = 0	// Slot of this way in the write broadcast
) (
	input logic clk,
	input logic nru_reset,
	input tlb_pkg::lookup_req_t lookup_i,
	input logic lookup_v_i,	// Accepted lookup
	input logic [tlb_pkg::SET_BITS-1:0] rd_set_i,
	input logic rd_v_i,
	input tlb_pkg::way_wr_t wr_i,
	output tlb_pkg::tlb_entry_t entry_o,
	output logic hit_o
);

	tlb_pkg::tlb_entry_t mem [tlb_pkg::TLB_SETS];	// Entry storage
	tlb_pkg::tlb_entry_t entry_q;	// Registered read data
	tlb_pkg::tlb_entry_t wb_entry;	// Hit entry with its NRU bit set
	tlb_pkg::lookup_req_t lkp_q;	// Request stage
	tlb_pkg::lookup_req_t cmp_q;	// Stage beside the read entry
	logic lkp_v_q;
	logic cmp_v_q;
	logic [tlb_pkg::SET_BITS-1:0] rd_addr;
	logic [tlb_pkg::SET_BITS-1:0] cmp_set;
	logic [tlb_pkg::TAG_W-1:0] cmp_tag;
	logic wb;

	// ==============================
	// Lookup pipeline
	// ==============================
	always_ff @(posedge clk)
	begin
		if (nru_reset)
		begin
			lkp_v_q <= 1'b0;
			cmp_v_q <= 1'b0;
		end
		else
		begin
			lkp_v_q <= lookup_v_i;
			cmp_v_q <= lkp_v_q;
		end
		lkp_q <= lookup_i;
		cmp_q <= lkp_q;	// Moves along with the memory read
	end

	// The fill controller only reads once the lookup pipe has drained
	always_comb
		rd_addr = rd_v_i ? rd_set_i :
			lkp_q.vadr[tlb_pkg::LOG_PAGESIZE +: tlb_pkg::SET_BITS];

	always_comb
	begin
		cmp_set = cmp_q.vadr[tlb_pkg::LOG_PAGESIZE +: tlb_pkg::SET_BITS];
		cmp_tag = cmp_q.vadr[tlb_pkg::VADR_W-1 -: tlb_pkg::TAG_W];
	end

	// ==============================
	// Compare
	// ==============================
	// Global pages ignore the address space id
	always_comb
		hit_o = cmp_v_q && entry_q.valid && (entry_q.tag == cmp_tag) &&
			(entry_q.glb || (entry_q.asid == cmp_q.asid));

	assign entry_o = entry_q;

	// Only write back when the bit actually changes
	always_comb
	begin
		wb = hit_o && !entry_q.nru;
		wb_entry = entry_q;
		wb_entry.nru = 1'b1;
	end

	// ==============================
	// Memory
	// ==============================
	always_ff @(posedge clk)
	begin
		if (wr_i.we[way_no])	// Fill and clear writes take priority
			mem[wr_i.set] <= wr_i.entry[way_no];
		else if (wb)
			mem[cmp_set] <= wb_entry;
		entry_q <= mem[rd_addr];	// Read returns the data before this edge's write
	end

endmodule

// ==== hw/tlb_fill_ctrl.sv ====
`timescale 1ns/1ps

module tlb_fill_ctrl (
	input logic clk,
	input logic nru_reset,
	input logic fill_req_i,
	input tlb_pkg::tlb_entry_t fill_entry_i,
	input tlb_pkg::tlb_entry_t [tlb_pkg::TLB_ASSOC-1:0] way_entry_i,
	output logic rdy_o,
	output logic fill_ack_o,
	output tlb_pkg::way_wr_t way_wr_o,
	output logic [tlb_pkg::SET_BITS-1:0] rd_set_o,
	output logic rd_v_o
);

	tlb_pkg::fill_state_e state_q;
	tlb_pkg::fill_state_e state_d;
	logic [tlb_pkg::SET_BITS-1:0] clr_cnt_q;	// Set being wiped in CLEAR
	logic drain_q;	// Second DRAIN cycle
	logic [tlb_pkg::WAY_BITS-1:0] victim_d;
	logic [tlb_pkg::WAY_BITS-1:0] victim_q;
	logic all_nru_d;
	logic all_nru_q;
	logic inv_found;	// Some way in the set is empty
	logic nru_found;	// Some valid way has its NRU bit clear

	// ==============================
	// Next state
	// ==============================
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			tlb_pkg::CLEAR:
				if (&clr_cnt_q)	// Last set wiped
					state_d = tlb_pkg::IDLE;
			tlb_pkg::IDLE:
				if (fill_req_i)
					state_d = tlb_pkg::DRAIN;
			tlb_pkg::DRAIN:
				if (drain_q)
					state_d = tlb_pkg::READ;
			tlb_pkg::READ: state_d = tlb_pkg::PICK;
			tlb_pkg::PICK: state_d = tlb_pkg::WRITE;
			tlb_pkg::WRITE: state_d = tlb_pkg::ACK;
			tlb_pkg::ACK:
				if (!fill_req_i)	// Walker has seen the acknowledge
					state_d = tlb_pkg::IDLE;
			default: state_d = tlb_pkg::CLEAR;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (nru_reset)
		begin
			state_q <= tlb_pkg::CLEAR;
			clr_cnt_q <= '0;
			drain_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			if (state_q == tlb_pkg::CLEAR)
				clr_cnt_q <= clr_cnt_q + 1'b1;
			drain_q <= (state_q == tlb_pkg::DRAIN) ? ~drain_q : 1'b0;
		end
	end

	// ==============================
	// Victim choice
	// ==============================
	// An empty way wins, then the first way not used recently
	always_comb
	begin
		victim_d = '0;	// Way 0 when every NRU bit is set
		inv_found = 1'b0;
		nru_found = 1'b0;
		for (int w = 0; w < tlb_pkg::TLB_ASSOC; w++)
		begin
			if (!way_entry_i[w].valid && !inv_found)
			begin
				victim_d = w[tlb_pkg::WAY_BITS-1:0];
				inv_found = 1'b1;
			end
		end
		for (int w = 0; w < tlb_pkg::TLB_ASSOC; w++)
		begin
			if (!inv_found && !nru_found && !way_entry_i[w].nru)
			begin
				victim_d = w[tlb_pkg::WAY_BITS-1:0];
				nru_found = 1'b1;
			end
		end
		all_nru_d = !inv_found && !nru_found;	// Others get their NRU bits cleared
	end

	always_ff @(posedge clk)
	begin
		if (state_q == tlb_pkg::PICK)
		begin
			victim_q <= victim_d;
			all_nru_q <= all_nru_d;
		end
	end

	// ==============================
	// Way writes
	// ==============================
	always_comb
	begin
		way_wr_o = '0;	// Idle default with no write enables
		case (state_q)
			tlb_pkg::CLEAR:
			begin
				way_wr_o.set = clr_cnt_q;
				way_wr_o.we = '1;	// All-invalid entry into every way
			end
			tlb_pkg::WRITE:
			begin
				way_wr_o.set = fill_entry_i.vset;
				// The set was reread in PICK so these are still current
				for (int w = 0; w < tlb_pkg::TLB_ASSOC; w++)
				begin
					way_wr_o.entry[w] = way_entry_i[w];
					way_wr_o.entry[w].nru = 1'b0;
				end
				if (all_nru_q)
					way_wr_o.we = '1;
				way_wr_o.entry[victim_q] = fill_entry_i;
				way_wr_o.entry[victim_q].nru = 1'b1;	// New entry counts as used
				way_wr_o.we[victim_q] = 1'b1;
			end
			default: way_wr_o = '0;
		endcase
	end

	// Read port is ours in READ and PICK so the entries stay put until WRITE
	assign rd_v_o = (state_q == tlb_pkg::READ) || (state_q == tlb_pkg::PICK);
	assign rd_set_o = fill_entry_i.vset;	// Walker holds the entry stable
	assign rdy_o = (state_q == tlb_pkg::IDLE) || (state_q == tlb_pkg::ACK);
	assign fill_ack_o = (state_q == tlb_pkg::ACK);	// Entry is written on entry to ACK

endmodule

// ==== hw/tlb_adr_mux.sv ====
`timescale 1ns/1ps

module tlb_adr_mux (
	input logic clk,
	input logic nru_reset,
	input logic paging_en_i,
	input tlb_pkg::lookup_req_t req_i,
	input logic req_v_i,
	input tlb_pkg::tlb_entry_t [tlb_pkg::TLB_ASSOC-1:0] entry_i,
	input logic [tlb_pkg::TLB_ASSOC-1:0] hit_i,
	output tlb_pkg::lookup_rsp_t rsp_o,
	output logic rsp_v_o
);

	tlb_pkg::lookup_req_t req_q;	// Accepted request
	tlb_pkg::lookup_req_t mem_q;	// Lines up with the entries out of the ways
	tlb_pkg::lookup_rsp_t rsp_d;
	logic req_v_q;
	logic mem_v_q;
	logic [tlb_pkg::PPN_W-1:0] ppn;	// Page number of the hitting way

	// ==============================
	// Request stages
	// ==============================
	always_ff @(posedge clk)
	begin
		if (nru_reset)
		begin
			req_v_q <= 1'b0;
			mem_v_q <= 1'b0;
		end
		else
		begin
			req_v_q <= req_v_i;
			mem_v_q <= req_v_q;
		end
		req_q <= req_i;
		mem_q <= req_q;
	end

	// ==============================
	// Address formation
	// ==============================
	always_comb
	begin
		ppn = '0;
		// At most one way hits so an OR of the gated page numbers is enough
		for (int w = 0; w < tlb_pkg::TLB_ASSOC; w++)
		begin
			if (hit_i[w])
				ppn = ppn | entry_i[w].ppn;
		end
		rsp_d.id = mem_q.id;
		rsp_d.asid = mem_q.asid;
		rsp_d.vadr = mem_q.vadr;	// Kept for miss reporting
		if (!paging_en_i)
		begin
			rsp_d.hit = 1'b1;	// Untranslated pass-through
			rsp_d.padr = mem_q.vadr;
		end
		else if (|hit_i)
		begin
			rsp_d.hit = 1'b1;
			rsp_d.padr = {ppn, mem_q.vadr[tlb_pkg::LOG_PAGESIZE-1:0]};
		end
		else
		begin
			rsp_d.hit = 1'b0;	// Miss
			rsp_d.padr = '0;
		end
	end

	// Response register
	always_ff @(posedge clk)
	begin
		if (nru_reset)
			rsp_v_o <= 1'b0;
		else
			rsp_v_o <= mem_v_q;	// One cycle wide, no back-pressure
		if (mem_v_q)
			rsp_o <= rsp_d;
	end

endmodule

// ==== hw/tlb_top.sv ====
`timescale 1ns/1ps

module tlb_top (
	input logic clk,
	input logic nru_reset,
	input logic paging_en_i,
	input tlb_pkg::lookup_req_t lookup_i,
	input logic lookup_v_i,
	output logic rdy_o,
	output tlb_pkg::lookup_rsp_t rsp_o,
	output logic rsp_v_o,
	input logic fill_req_i,
	input tlb_pkg::tlb_entry_t fill_entry_i,
	output logic fill_ack_o
);

	logic lookup_acc;	// Lookup taken this cycle
	logic [tlb_pkg::SET_BITS-1:0] rd_set;
	logic rd_v;
	tlb_pkg::way_wr_t way_wr;
	tlb_pkg::tlb_entry_t [tlb_pkg::TLB_ASSOC-1:0] way_entry;
	logic [tlb_pkg::TLB_ASSOC-1:0] way_hit;

	assign lookup_acc = lookup_v_i & rdy_o;	// Caller holds its request while not ready

	// ==============================
	// Fill and clear
	// ==============================
	tlb_fill_ctrl u_fill_ctrl (
		.clk(clk),
		.nru_reset(nru_reset),
		.fill_req_i(fill_req_i),
		.fill_entry_i(fill_entry_i),
		.way_entry_i(way_entry),
		.rdy_o(rdy_o),
		.fill_ack_o(fill_ack_o),
		.way_wr_o(way_wr),
		.rd_set_o(rd_set),
		.rd_v_o(rd_v)
	);

	// ==============================
	// Ways
	// ==============================
	for (genvar g = 0; g < tlb_pkg::TLB_ASSOC; g++)
	begin : gWays
		// Every way sees the same lookup and write broadcast
		tlb_way #(
			.way_no(g)
		) u_way (
			.clk(clk),
			.nru_reset(nru_reset),
			.lookup_i(lookup_i),
			.lookup_v_i(lookup_acc),
			.rd_set_i(rd_set),
			.rd_v_i(rd_v),
			.wr_i(way_wr),
			.entry_o(way_entry[g]),
			.hit_o(way_hit[g])
		);
	end

	// ==============================
	// Response
	// ==============================
	tlb_adr_mux u_adr_mux (
		.clk(clk),
		.nru_reset(nru_reset),
		.paging_en_i(paging_en_i),
		.req_i(lookup_i),
		.req_v_i(lookup_acc),
		.entry_i(way_entry),
		.hit_i(way_hit),
		.rsp_o(rsp_o),
		.rsp_v_o(rsp_v_o)
	);

endmodule

// ==== test/tlb_sva.sv ====
`timescale 1ns/1ps

module tlb_sva (
	input logic clk,
	input logic nru_reset,
	input logic lookup_v_i,
	input logic rdy_o,
	input logic rsp_v_o,
	input logic fill_req_i,
	input logic fill_ack_o
);

	logic [5:0] since_rst;	// Cycles since reset, saturating

	always_ff @(posedge clk)
	begin
		if (nru_reset)
			since_rst <= '0;
		else if (since_rst != 6'd63)
			since_rst <= since_rst + 6'd1;
	end

	// ==============================
	// Fill handshake
	// ==============================
	ack_needs_req: assert property (@(posedge clk) disable iff (nru_reset)
		$rose(fill_ack_o) |-> fill_req_i)
		else $error("fill_ack_o rose while fill_req_i was low");

	// The response register is set two edges after acceptance and sampled on the third
	rsp_after_lookup: assert property (@(posedge clk) disable iff (nru_reset)
		rsp_v_o == $past(lookup_v_i && rdy_o, 3))
		else $error("rsp_v_o does not line up with an accepted lookup");

	// ==============================
	// Reset and clear
	// ==============================
	clear_holds_rdy: assert property (@(posedge clk) disable iff (nru_reset)
		(since_rst < 6'd32) |-> !rdy_o)
		else $error("rdy_o rose before all sets were cleared");
	clear_ends: assert property (@(posedge clk) disable iff (nru_reset)
		(since_rst == 6'd32) |-> rdy_o)
		else $error("rdy_o did not rise after the clear");
	reset_quiet: assert property (@(posedge clk)
		$past(nru_reset) |-> (!rsp_v_o && !fill_ack_o && !rdy_o))
		else $error("Outputs active right after reset");

endmodule

// Checker rides along with every TLB top level
bind tlb_top tlb_sva tlb_sva_inst (
	.clk(clk),
	.nru_reset(nru_reset),
	.lookup_v_i(lookup_v_i),
	.rdy_o(rdy_o),
	.rsp_v_o(rsp_v_o),
	.fill_req_i(fill_req_i),
	.fill_ack_o(fill_ack_o)
);

// ==== test/tb_tlb.sv ====
`timescale 1ns/1ps

module tb_tlb;

	localparam int WAIT_LIMIT = 200;	// Cycles any single wait may take

	// Expected response with the cycle its lookup was taken
	typedef struct packed {
		tlb_pkg::lookup_rsp_t rsp;
		logic [31:0] acc_cycle;
	} expect_t;

	logic clk;
	logic nru_reset;
	logic paging_en_i;
	tlb_pkg::lookup_req_t lookup_i;
	logic lookup_v_i;
	logic rdy_o;
	tlb_pkg::lookup_rsp_t rsp_o;
	logic rsp_v_o;
	logic fill_req_i;
	tlb_pkg::tlb_entry_t fill_entry_i;
	logic fill_ack_o;

	integer seed = 11092;
	logic [31:0] cycle;
	expect_t exp_q [$];	// Responses still to come, oldest first
	tlb_pkg::tlb_entry_t model_mem [tlb_pkg::TLB_ASSOC][tlb_pkg::TLB_SETS];
	tlb_pkg::tlb_entry_t pages [4];	// Pages spread over several sets
	tlb_pkg::tlb_entry_t set_pages [6];	// Pages that all fall into set 7

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk)
		cycle <= nru_reset ? 32'd0 : cycle + 32'd1;

	tlb_top tlb_top_inst (
		.clk(clk),
		.nru_reset(nru_reset),
		.paging_en_i(paging_en_i),
		.lookup_i(lookup_i),
		.lookup_v_i(lookup_v_i),
		.rdy_o(rdy_o),
		.rsp_o(rsp_o),
		.rsp_v_o(rsp_v_o),
		.fill_req_i(fill_req_i),
		.fill_entry_i(fill_entry_i),
		.fill_ack_o(fill_ack_o)
	);

	// ==============================
	// Reference model
	// ==============================
	function automatic logic [31:0] next_random();
		logic [31:0] r;
		r = $random(seed);
		return r;
	endfunction

	function automatic tlb_pkg::tlb_entry_t make_entry(input logic [31:0] vadr,
		input logic [tlb_pkg::ASID_W-1:0] asid, input logic glb,
		input logic [tlb_pkg::PPN_W-1:0] ppn);
		tlb_pkg::tlb_entry_t e;
		e = '0;	// NRU is left clear, the TLB sets it itself
		e.valid = 1'b1;
		e.glb = glb;
		e.asid = asid;
		e.vset = vadr[tlb_pkg::LOG_PAGESIZE +: tlb_pkg::SET_BITS];
		e.tag = vadr[31 -: tlb_pkg::TAG_W];
		e.ppn = ppn;
		return e;
	endfunction

	// Empty way first, then first clear NRU bit, else way 0 and clear the rest
	function automatic void apply_fill(input tlb_pkg::tlb_entry_t e);
		int victim;
		logic found;
		victim = 0;
		found = 1'b0;
		for (int w = 0; w < tlb_pkg::TLB_ASSOC; w++)
			if (!found && !model_mem[w][e.vset].valid)
			begin
				victim = w;
				found = 1'b1;
			end
		for (int w = 0; w < tlb_pkg::TLB_ASSOC; w++)
			if (!found && !model_mem[w][e.vset].nru)
			begin
				victim = w;
				found = 1'b1;
			end
		if (!found)
			for (int w = 0; w < tlb_pkg::TLB_ASSOC; w++)
				model_mem[w][e.vset].nru = 1'b0;
		model_mem[victim][e.vset] = e;
		model_mem[victim][e.vset].nru = 1'b1;	// A fresh entry counts as used
	endfunction

	function automatic tlb_pkg::lookup_rsp_t expected_response(
		input tlb_pkg::lookup_req_t req, input logic paging);
		tlb_pkg::lookup_rsp_t rsp;
		logic [tlb_pkg::SET_BITS-1:0] set;
		logic [tlb_pkg::TAG_W-1:0] tag;
		set = req.vadr[tlb_pkg::LOG_PAGESIZE +: tlb_pkg::SET_BITS];
		tag = req.vadr[31 -: tlb_pkg::TAG_W];
		rsp.id = req.id;
		rsp.asid = req.asid;
		rsp.vadr = req.vadr;
		rsp.hit = !paging;	// Untranslated lookups always hit
		rsp.padr = paging ? 32'd0 : req.vadr;
		if (paging)
			for (int w = 0; w < tlb_pkg::TLB_ASSOC; w++)
				if (model_mem[w][set].valid && model_mem[w][set].tag == tag &&
					(model_mem[w][set].glb || model_mem[w][set].asid == req.asid))
				begin
					rsp.hit = 1'b1;
					rsp.padr = {model_mem[w][set].ppn,
						req.vadr[tlb_pkg::LOG_PAGESIZE-1:0]};
					model_mem[w][set].nru = 1'b1;
				end
		return rsp;
	endfunction

	function automatic tlb_pkg::lookup_req_t random_request();
		tlb_pkg::lookup_req_t req;
		logic [31:0] rnd;
		rnd = next_random();
		req.id = rnd[3:0];
		req.asid = rnd[11:4];
		req.vadr = next_random();
		return req;
	endfunction

	function automatic tlb_pkg::lookup_req_t page_request(input tlb_pkg::tlb_entry_t e,
		input logic [tlb_pkg::ASID_W-1:0] asid);
		tlb_pkg::lookup_req_t req;
		logic [31:0] rnd;
		rnd = next_random();
		req.id = rnd[15:12];
		req.asid = asid;
		req.vadr = {e.tag, e.vset, rnd[11:0]};	// Random offset inside the page
		return req;
	endfunction

	// ==============================
	// Failure reporting
	// ==============================
	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped on a failure");
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] want);
		$display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
		$display("*** FAILED ***");
		$fatal(1, "Response check failed");
	endtask

	// ==============================
	// Drivers
	// ==============================
	// Called 1 ns after an edge and returns 1 ns after the accepting edge
	task automatic send_lookup(input tlb_pkg::lookup_req_t req);
		int waited;
		expect_t e;
		lookup_i = req;
		lookup_v_i = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!rdy_o)
		begin
			if (waited == WAIT_LIMIT)
				stop_with_failure("Timeout: rdy_o stayed low while a lookup waited");
			else
			begin
				waited++;
				@(negedge clk);
			end
		end
		// rdy_o only moves on an edge so the coming edge takes the lookup
		e.rsp = expected_response(req, paging_en_i);
		e.acc_cycle = cycle + 32'd1;
		exp_q.push_back(e);
		@(posedge clk);
		#1;
		lookup_v_i = 1'b0;
	endtask

	task automatic fill_page(input tlb_pkg::tlb_entry_t entry);
		int waited;
		fill_entry_i = entry;
		fill_req_i = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!fill_ack_o)
		begin
			if (waited == WAIT_LIMIT)
				stop_with_failure("Timeout: fill_ack_o never rose for a fill request");
			else
			begin
				waited++;
				@(negedge clk);
			end
		end
		apply_fill(entry);
		@(posedge clk);
		#1;
		fill_req_i = 1'b0;	// Four-phase: drop the request, then see ack fall
		waited = 0;
		@(negedge clk);
		while (fill_ack_o)
		begin
			if (waited == WAIT_LIMIT)
				stop_with_failure("Timeout: fill_ack_o stayed high after the request fell");
			else
			begin
				waited++;
				@(negedge clk);
			end
		end
		@(posedge clk);
		#1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic wait_responses();
		int waited;
		waited = 0;
		while (exp_q.size() != 0)
		begin
			if (waited == WAIT_LIMIT)
				stop_with_failure("Timeout: responses still missing for sent lookups");
			else
			begin
				waited++;
				@(negedge clk);
			end
		end
		@(posedge clk);
		#1;
	endtask

	// ==============================
	// Compare
	// ==============================
	always @(negedge clk)
	begin : compare_rsp
		expect_t e;
		if (!nru_reset && rsp_v_o)
		begin
			assert (exp_q.size() != 0)
			else stop_with_failure("rsp_v_o rose with no lookup outstanding");
			if (exp_q.size() != 0)
			begin
				e = exp_q.pop_front();
				assert (cycle == e.acc_cycle + 32'd2)	// Two cycles after acceptance
				else report_mismatch("rsp_v_o cycle", 128'(cycle), 128'(e.acc_cycle + 32'd2));
				assert ({rsp_o.id, rsp_o.hit, rsp_o.asid, rsp_o.vadr} ==
					{e.rsp.id, e.rsp.hit, e.rsp.asid, e.rsp.vadr})
				else report_mismatch("rsp_o", 128'(rsp_o), 128'(e.rsp));
				if (e.rsp.hit)
					assert (rsp_o.padr == e.rsp.padr)
					else report_mismatch("rsp_o.padr", 128'(rsp_o.padr), 128'(e.rsp.padr));
			end
		end
	end

	// ==============================
	// Stimulus
	// ==============================
	initial
	begin : stimulus
		logic [31:0] rnd;
		nru_reset = 1'b1;
		paging_en_i = 1'b1;
		lookup_i = '0;
		lookup_v_i = 1'b0;
		fill_req_i = 1'b0;
		fill_entry_i = '0;
		for (int w = 0; w < tlb_pkg::TLB_ASSOC; w++)
			for (int s = 0; s < tlb_pkg::TLB_SETS; s++)
				model_mem[w][s] = '0;
		pages[0] = make_entry(32'h1234_5000, 8'd5, 1'b0, 20'hABCDE);
		pages[1] = make_entry(32'h00AB_C000, 8'd5, 1'b0, 20'h11111);
		pages[2] = make_entry(32'h7FFF_3000, 8'd6, 1'b0, 20'h22222);
		pages[3] = make_entry(32'h4002_1000, 8'd5, 1'b1, 20'h33333);	// Global page
		for (int i = 0; i < 6; i++)
			set_pages[i] = make_entry({15'h100 + 15'(i), 5'd7, 12'h000}, 8'd3, 1'b0,
				20'h50000 + 20'(i));
		repeat (10) @(posedge clk);
		#1;
		nru_reset = 1'b0;
		assert (!rsp_v_o && !fill_ack_o && !rdy_o)
		else stop_with_failure("rsp_v_o, fill_ack_o or rdy_o high right after reset");

		// Empty TLB, so every lookup misses
		repeat (20)
		begin
			rnd = next_random();
			send_lookup(random_request());
			idle_cycles(int'(rnd[1:0]));
		end
		wait_responses();

		// Own asid hits, foreign asid only hits the global page
		for (int i = 0; i < 4; i++)
			fill_page(pages[i]);
		for (int i = 0; i < 4; i++)
		begin
			send_lookup(page_request(pages[i], pages[i].asid));
			send_lookup(page_request(pages[i], 8'd9));
		end
		wait_responses();

		// One lookup per cycle with hits and misses mixed
		for (int i = 0; i < 40; i++)
		begin
			rnd = next_random();
			if (rnd[0])
				send_lookup(page_request(pages[rnd[2:1]],
					rnd[3] ? pages[rnd[2:1]].asid : rnd[11:4]));
			else
				send_lookup(random_request());
		end
		wait_responses();

		// Fill a set, then replace under all NRU bits set and under a clear one
		for (int i = 0; i < 4; i++)
			fill_page(set_pages[i]);
		for (int i = 0; i < 3; i++)
			send_lookup(page_request(set_pages[i], 8'd3));
		fill_page(set_pages[4]);	// All bits set so way 0 goes
		send_lookup(page_request(set_pages[1], 8'd3));
		send_lookup(page_request(set_pages[2], 8'd3));
		fill_page(set_pages[5]);	// Way 3 is the only one left unused
		for (int i = 0; i < 6; i++)
			send_lookup(page_request(set_pages[i], 8'd3));
		wait_responses();

		paging_en_i = 1'b0;	// Pipe is empty here
		repeat (20)
			send_lookup(random_request());
		wait_responses();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== verilog.f ====
hw/tlb_pkg.sv
hw/tlb_way.sv
hw/tlb_fill_ctrl.sv
hw/tlb_adr_mux.sv
hw/tlb_top.sv
test/tlb_sva.sv
test/tb_tlb.sv

// ==== Makefile ====
# Sources come from the file list so both stay in step
SRCS := $(shell cat verilog.f)

.PHONY: all run clean

all: obj_dir/Vtb_tlb

# Rebuilt only when a source or the list itself changes
obj_dir/Vtb_tlb: verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tlb \
		-Mdir obj_dir -f verilog.f

# The exit status of the simulator is the test result
run: obj_dir/Vtb_tlb
	./obj_dir/Vtb_tlb

clean:
	rm -rf obj_dir
